/* files.f */
src/limb_pkg.sv
src/param_bank.sv
src/wave_buffer.sv
src/sim_sequencer.sv
src/spike_window_counter.sv
src/limb_loop_top.sv
sim/limb_loop_assert.sv
sim/tb_limb_loop.sv

/* Bender.yml */
package:
  name: limb_loop

sources:
  # rtl, package first
  - src/limb_pkg.sv
  - src/param_bank.sv
  - src/wave_buffer.sv
  - src/sim_sequencer.sv
  - src/spike_window_counter.sv
  - src/limb_loop_top.sv
  # testbench and bound checks
  - target: simulation
    files:
      - sim/limb_loop_assert.sv
      - sim/tb_limb_loop.sv

/* sim/tb_limb_loop.sv */
module tb_limb_loop;
    import limb_pkg::*;

    localparam int CLK_PERIOD = 8;
    // longest tick period the random half count can give
    localparam int MAX_PERIOD = 42;
    // o_len_valid pulses waited for in each test
    localparam int T1_TICKS = 6;
    localparam int T2_TICKS = 6;
    localparam int T3_TICKS = 12;
    localparam int T4_TICKS = 10;
    localparam int T5_TICKS = 10;
    localparam int T6_TICKS = 13;
    localparam int RUN_CYCLES = (T1_TICKS + T2_TICKS + T3_TICKS) * 10
                              + (T4_TICKS + T5_TICKS + T6_TICKS) * MAX_PERIOD;
    localparam int WATCHDOG_TIME = RUN_CYCLES * CLK_PERIOD * 3 / 2;

    // dut ports
    logic               ep50trig;
    logic               reset_global;
    logic [15:0]        i_trig;
    half_t              i_wire_lo;
    half_t              i_wire_hi;
    logic               i_pipe_write;
    half_t              i_pipe_data;
    logic               i_sim_reset;
    logic               i_mn_spike;
    logic               o_sim_tick;
    word_t              o_len;
    logic               o_len_valid;
    logic [COUNT_W-1:0] o_spike_count;
    logic               o_count_valid;

    integer seed;

    // model of the parameter bank
    logic [HALF_CNT_W-1:0] m_half_cnt;
    logic                  m_use_pxi;
    word_t                 m_len_pxi;
    // model of the tick divider, m_tick is the expected tick of the current cycle
    logic m_tick;
    int   m_elapsed;
    int   m_period;
    // model of the waveform buffer
    word_t m_mem [WAVE_DEPTH];
    int    m_wr;
    int    m_rd;
    int    m_stored;
    logic  m_have_lo;
    half_t m_lo;
    // spikes in the open window
    int m_spikes;

    // expected strobes still in flight
    word_t              len_q[$];
    logic [COUNT_W-1:0] count_q[$];

    // o_len_valid spacing
    logic spacing_on = 1'b1;
    int   exp_period = 10;
    logic have_last = 1'b0;
    int   cyc = 0;
    int   last_valid_cyc = 0;

    int len_errors = 0;
    int count_errors = 0;
    int tick_errors = 0;
    int other_errors = 0;

    initial ep50trig = 1'b0;
    always #(CLK_PERIOD / 2) ep50trig = ~ep50trig;

    limb_loop_top UUT (
        .i_clk         (ep50trig),
        .reset_global  (reset_global),
        .i_trig        (i_trig),
        .i_wire_lo     (i_wire_lo),
        .i_wire_hi     (i_wire_hi),
        .i_pipe_write  (i_pipe_write),
        .i_pipe_data   (i_pipe_data),
        .i_sim_reset   (i_sim_reset),
        .i_mn_spike    (i_mn_spike),
        .o_sim_tick    (o_sim_tick),
        .o_len         (o_len),
        .o_len_valid   (o_len_valid),
        .o_spike_count (o_spike_count),
        .o_count_valid (o_count_valid)
    );

    // strobe latency checks on both tick consumers
    bind sim_sequencer limb_loop_assert #(
        .LATENCY     (2),
        .STROBE_NAME ("o_len_valid")
    ) u_len_assert (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_sim_reset (i_sim_reset),
        .i_tick      (o_tick),
        .i_strobe    (o_len_valid)
    );

    bind spike_window_counter limb_loop_assert #(
        .LATENCY     (1),
        .STROBE_NAME ("o_count_valid")
    ) u_count_assert (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_sim_reset (i_sim_reset),
        .i_tick      (i_tick),
        .i_strobe    (o_count_valid)
    );

    ////////////////////
    // reference
    ////////////////////

    // length shown for a tick, given the selector and buffer state at that tick
    function automatic word_t exp_len(input logic use_fixed, input word_t fixed_len,
                                      input int stored, input int rd);
        if (use_fixed)
            return fixed_len;
        if (stored == 0)
            return '0;
        return m_mem[rd];
    endfunction

    // window total, the tick cycle spike included, held at the top
    function automatic logic [COUNT_W-1:0] exp_count(input int spikes, input logic spike_now);
        int total;
        total = spikes + spike_now;
        if (total > 65535)
            total = 65535;
        return COUNT_W'(total);
    endfunction

    // sees the same cycle values as the dut registers
    always @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            m_half_cnt = DEF_HALF_CNT;
            m_use_pxi  = DEF_USE_PXI;
            m_len_pxi  = DEF_LEN_PXI;
            m_elapsed  = 0;
            m_period   = 2 * (DEF_HALF_CNT + 1);
            m_tick    <= 1'b0;
            m_wr       = 0;
            m_rd       = 0;
            m_stored   = 0;
            m_have_lo  = 1'b0;
            m_spikes   = 0;
        end
        else
        begin
            if (i_sim_reset)
            begin
                m_elapsed = 0;
                m_period  = 2 * (m_half_cnt + 1);
                m_tick   <= 1'b0;
                m_wr      = 0;
                m_rd      = 0;
                m_stored  = 0;
                m_have_lo = 1'b0;
                m_spikes  = 0;
            end
            else
            begin
                // pop sees the buffer before this cycle's store
                if (m_tick)
                begin
                    len_q.push_back(exp_len(m_use_pxi, m_len_pxi, m_stored, m_rd));
                    count_q.push_back(exp_count(m_spikes, i_mn_spike));
                    m_spikes = 0;
                    if (m_stored != 0)
                        m_rd = (m_rd + 1 >= m_stored) ? 0 : m_rd + 1;
                end
                else
                    m_spikes = m_spikes + i_mn_spike;
                // tick once per period, half count taken at each restart
                m_elapsed = m_elapsed + 1;
                if (m_elapsed == m_period)
                begin
                    m_elapsed = 0;
                    m_period  = 2 * (m_half_cnt + 1);
                    m_tick   <= 1'b1;
                end
                else
                    m_tick <= 1'b0;
                // low half first, sample lands on the high half
                if (i_pipe_write && !m_have_lo)
                begin
                    m_lo      = i_pipe_data;
                    m_have_lo = 1'b1;
                end
                else if (i_pipe_write)
                begin
                    m_mem[m_wr] = {i_pipe_data, m_lo};
                    m_wr        = (m_wr + 1) % WAVE_DEPTH;
                    m_have_lo   = 1'b0;
                    if (m_stored < WAVE_DEPTH)
                        m_stored = m_stored + 1;
                end
            end
            // params not touched by the sim clear
            if (i_trig[TRIG_HALF_CNT])
                m_half_cnt = HALF_CNT_W'(i_wire_lo);
            if (i_trig[TRIG_LEN_SELECT])
                m_use_pxi = (i_wire_hi != 16'd0) || (i_wire_lo != 16'd0);
            if (i_trig[TRIG_LEN_PXI])
                m_len_pxi = {i_wire_hi, i_wire_lo};
        end
    end

    ////////////////////
    // comparator
    ////////////////////

    always @(posedge ep50trig)
    begin : compare
        word_t              exp_l;
        logic [COUNT_W-1:0] exp_c;
        cyc = cyc + 1;
        if (!reset_global)
        begin
            assert (o_sim_tick === m_tick)
            else
            begin
                $display("[ERROR] %0t o_sim_tick expected %b actual %b",
                         $time, m_tick, o_sim_tick);
                tick_errors++;
            end
        end
        if (!reset_global && o_len_valid)
        begin
            assert (len_q.size() != 0)
            else
            begin
                $display("%0t: o_len_valid pulsed with no tick waiting for it", $time);
                other_errors++;
            end
            if (len_q.size() != 0)
            begin
                exp_l = len_q.pop_front();
                assert (o_len === exp_l)
                else
                begin
                    $display("[ERROR] %0t o_len expected %h actual %h", $time, exp_l, o_len);
                    len_errors++;
                end
            end
            if (spacing_on && have_last)
            begin
                assert (cyc - last_valid_cyc == exp_period)
                else
                begin
                    $display("[ERROR] %0t o_len_valid spacing expected %0d actual %0d",
                             $time, exp_period, cyc - last_valid_cyc);
                    tick_errors++;
                end
            end
            have_last      = spacing_on;
            last_valid_cyc = cyc;
        end
        if (!reset_global && o_count_valid)
        begin
            assert (count_q.size() != 0)
            else
            begin
                $display("%0t: o_count_valid pulsed with no tick waiting for it", $time);
                other_errors++;
            end
            if (count_q.size() != 0)
            begin
                exp_c = count_q.pop_front();
                assert (o_spike_count === exp_c)
                else
                begin
                    $display("[ERROR] %0t o_spike_count expected %0d actual %0d",
                             $time, exp_c, o_spike_count);
                    count_errors++;
                end
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // all tasks start and end on a falling edge
    task automatic wait_lens(input int n);
        int seen;
        seen = 0;
        while (seen < n)
        begin
            @(posedge ep50trig);
            if (o_len_valid)
                seen++;
        end
        @(negedge ep50trig);
    endtask

    task automatic load_param(input trig_slot_e slot, input half_t hi, input half_t lo);
        i_wire_hi    = hi;
        i_wire_lo    = lo;
        i_trig       = '0;
        i_trig[slot] = 1'b1;
        @(negedge ep50trig);
        i_trig = '0;
    endtask

    task automatic write_sample(input word_t w);
        i_pipe_write = 1'b1;
        i_pipe_data  = w[15:0];
        @(negedge ep50trig);
        i_pipe_data = w[31:16];
        @(negedge ep50trig);
        i_pipe_write = 1'b0;
    endtask

    task automatic pulse_sim_reset;
        i_sim_reset = 1'b1;
        @(negedge ep50trig);
        i_sim_reset = 1'b0;
    endtask

    initial
    begin
        int half_val;
        int n;
        int total;
        seed         = 38;
        reset_global = 1'b1;
        i_trig       = '0;
        i_wire_lo    = '0;
        i_wire_hi    = '0;
        i_pipe_write = 1'b0;
        i_pipe_data  = '0;
        i_sim_reset  = 1'b0;
        i_mn_spike   = 1'b0;
        repeat (4) @(negedge ep50trig);
        reset_global = 1'b0;

        // defaults, fixed 0.9 every 10 cycles
        wait_lens(T1_TICKS);

        // fixed length from random wires
        load_param(TRIG_LEN_PXI, half_t'($random(seed)), half_t'($random(seed)));
        wait_lens(T2_TICKS);

        // samples go in while fixed length still shown, then switch to playback
        repeat (5) write_sample($random(seed));
        load_param(TRIG_LEN_SELECT, '0, '0);
        wait_lens(T3_TICKS);

        // new half count takes hold after the divider restarts
        spacing_on = 1'b0;
        half_val   = 1 + ($unsigned($random(seed)) % 20);
        load_param(TRIG_HALF_CNT, '0, half_t'(half_val));
        wait_lens(2);
        exp_period = 2 * (m_half_cnt + 1);
        spacing_on = 1'b1;
        wait_lens(T4_TICKS - 2);

        // random spikes, about one cycle in four
        n = 0;
        while (n < T5_TICKS)
        begin
            i_mn_spike = (($random(seed) & 3) == 0);
            @(posedge ep50trig);
            if (o_len_valid)
                n++;
            @(negedge ep50trig);
        end
        i_mn_spike = 1'b0;

        // sim clear empties playback, divider restarts too
        spacing_on = 1'b0;
        pulse_sim_reset;
        wait_lens(3);
        repeat (3) write_sample($random(seed));
        wait_lens(2);
        spacing_on = 1'b1;
        wait_lens(T6_TICKS - 5);

        // next tick is at least 4 cycles off, nothing should be pending
        assert (len_q.size() == 0 && count_q.size() == 0)
        else
        begin
            $display("%0t: a tick was never followed by its strobe", $time);
            other_errors++;
        end

        total = len_errors + count_errors + tick_errors + other_errors
              + UUT.u_sim_sequencer.u_len_assert.fail_count
              + UUT.u_spike_window_counter.u_count_assert.fail_count;
        $display("errors: o_len %0d, o_spike_count %0d, tick %0d, other %0d, bound %0d",
                 len_errors, count_errors, tick_errors, other_errors,
                 UUT.u_sim_sequencer.u_len_assert.fail_count
                 + UUT.u_spike_window_counter.u_count_assert.fail_count);
        if (total == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // watchdog, limit from the tick budget of all tests
    initial
    begin
        #(WATCHDOG_TIME);
        $display("timeout: run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* sim/limb_loop_assert.sv */
module limb_loop_assert #(
    parameter int    LATENCY     = 1,
    parameter string STROBE_NAME = "strobe"
) (
    input logic i_clk,
    input logic i_reset,
    input logic i_sim_reset,
    input logic i_tick,
    input logic i_strobe
);
    // failures seen, read back by the testbench
    int fail_count = 0;

    ////////////////////
    // strobe timing
    ////////////////////

    // every tick produces its strobe after the fixed latency
    tick_to_strobe: assert property (
        @(posedge i_clk) disable iff (i_reset || i_sim_reset)
        i_tick |-> ##LATENCY i_strobe
    )
    else
    begin
        $error("%s missing %0d cycles after tick", STROBE_NAME, LATENCY);
        fail_count++;
    end

    // and no strobe without a tick behind it
    strobe_from_tick: assert property (
        @(posedge i_clk) disable iff (i_reset || i_sim_reset)
        i_strobe |-> $past(i_tick, LATENCY)
    )
    else
    begin
        $error("%s without a tick %0d cycles earlier", STROBE_NAME, LATENCY);
        fail_count++;
    end

    // either reset leaves the strobe low on the next cycle
    quiet_after_reset: assert property (
        @(posedge i_clk)
        (i_reset || i_sim_reset) |=> !i_strobe
    )
    else
    begin
        $error("%s high right after a reset cycle", STROBE_NAME);
        fail_count++;
    end

endmodule

/* src/limb_loop_top.sv */
module limb_loop_top (
    input  logic                         i_clk,
    input  logic                         reset_global,
    input  logic [15:0]                  i_trig,
    input  limb_pkg::half_t              i_wire_lo,
    input  limb_pkg::half_t              i_wire_hi,
    input  logic                         i_pipe_write,
    input  limb_pkg::half_t              i_pipe_data,
    input  logic                         i_sim_reset,
    input  logic                         i_mn_spike,
    output logic                         o_sim_tick,
    output limb_pkg::word_t              o_len,
    output logic                         o_len_valid,
    output logic [limb_pkg::COUNT_W-1:0] o_spike_count,
    output logic                         o_count_valid
);
    import limb_pkg::*;

    // parameter levels
    logic [HALF_CNT_W-1:0] half_cnt;
    logic                  use_pxi;
    word_t                 len_pxi;

    // sequencer to buffer
    logic  pop;
    word_t sample;
    logic  sample_valid;

    ////////////////////
    // input side
    ////////////////////

    // host parameters, cleared by global reset only
    param_bank u_param_bank (
        .i_clk      (i_clk),
        .i_reset    (reset_global),
        .i_trig     (i_trig),
        .i_wire_lo  (i_wire_lo),
        .i_wire_hi  (i_wire_hi),
        .o_half_cnt (half_cnt),
        .o_use_pxi  (use_pxi),
        .o_len_pxi  (len_pxi)
    );

    wave_buffer u_wave_buffer (
        .i_clk          (i_clk),
        .i_reset        (reset_global),
        .i_sim_reset    (i_sim_reset),
        .i_pipe_write   (i_pipe_write),
        .i_pipe_data    (i_pipe_data),
        .i_pop          (pop),
        .o_sample       (sample),
        .o_sample_valid (sample_valid)
    );

    ////////////////////
    // processing
    ////////////////////

    sim_sequencer u_sim_sequencer (
        .i_clk          (i_clk),
        .i_reset        (reset_global),
        .i_sim_reset    (i_sim_reset),
        .i_half_cnt     (half_cnt),
        .i_use_pxi      (use_pxi),
        .i_len_pxi      (len_pxi),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .o_pop          (pop),
        .o_tick         (o_sim_tick),
        .o_len          (o_len),
        .o_len_valid    (o_len_valid)
    );

    ////////////////////
    // output side
    ////////////////////

    // motor-neuron spikes binned per tick
    spike_window_counter u_spike_window_counter (
        .i_clk         (i_clk),
        .i_reset       (reset_global),
        .i_sim_reset   (i_sim_reset),
        .i_spike       (i_mn_spike),
        .i_tick        (o_sim_tick),
        .o_count       (o_spike_count),
        .o_count_valid (o_count_valid)
    );

endmodule

/* src/spike_window_counter.sv */
module spike_window_counter (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_sim_reset,
    input  logic                         i_spike,
    input  logic                         i_tick,
    output logic [limb_pkg::COUNT_W-1:0] o_count,
    output logic                         o_count_valid
);
    import limb_pkg::*;

    // running count of the open window
    logic [COUNT_W-1:0] acc;
    // acc plus this cycle's spike, held at all ones
    logic [COUNT_W-1:0] acc_next;

    logic clear;

    assign clear = i_reset | i_sim_reset;

    // saturate rather than wrap
    assign acc_next = (i_spike && (acc != '1)) ? acc + 1'b1 : acc;

    ////////////////////
    // window close
    ////////////////////

    // tick cycle spike still belongs to the closing window
    always_ff @(posedge i_clk)
    begin
        if (clear)
        begin
            acc           <= '0;
            o_count       <= '0;
            o_count_valid <= 1'b0;
        end
        else if (i_tick)
        begin
            acc           <= '0;
            o_count       <= acc_next;
            o_count_valid <= 1'b1;
        end
        else
        begin
            acc           <= acc_next;
            o_count_valid <= 1'b0;
        end
    end

endmodule

/* src/sim_sequencer.sv */
module sim_sequencer (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_sim_reset,
    input  logic [limb_pkg::HALF_CNT_W-1:0] i_half_cnt,
    input  logic                            i_use_pxi,
    input  limb_pkg::word_t                 i_len_pxi,
    input  limb_pkg::word_t                 i_sample,
    input  logic                            i_sample_valid,
    output logic                            o_pop,
    output logic                            o_tick,
    output limb_pkg::word_t                 o_len,
    output logic                            o_len_valid
);
    import limb_pkg::*;

    // divider state
    logic [HALF_CNT_W-1:0] cur_half;
    logic [HALF_CNT_W:0]   div_cnt;
    logic [HALF_CNT_W:0]   div_last;
    logic                  tick_q;

    // selection captured on the tick
    logic  use_cap;
    word_t len_cap;

    logic clear;

    assign clear = i_reset | i_sim_reset;

    // full period is 2 * (half + 1), so last count is 2 * half + 1
    assign div_last = {cur_half, 1'b1};

    ////////////////////
    // tick divider
    ////////////////////

    // half count is taken only at a restart
    always_ff @(posedge i_clk)
    begin
        if (clear)
        begin
            div_cnt  <= '0;
            cur_half <= i_half_cnt;
            tick_q   <= 1'b0;
        end
        else if (div_cnt == div_last)
        begin
            div_cnt  <= '0;
            cur_half <= i_half_cnt;
            tick_q   <= 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            tick_q  <= 1'b0;
        end
    end

    // pop every tick so playback keeps moving under the fixed length
    assign o_tick = tick_q;
    assign o_pop  = tick_q;

    ////////////////////
    // length select
    ////////////////////

    always_ff @(posedge i_clk)
    begin
        if (clear)
            use_cap <= DEF_USE_PXI;
        else if (tick_q)
            use_cap <= i_use_pxi;
    end

    always_ff @(posedge i_clk)
    begin
        if (tick_q)
            len_cap <= i_len_pxi;
    end

    // sample returns one cycle after the pop, output one more later
    always_ff @(posedge i_clk)
    begin
        if (clear)
        begin
            o_len       <= '0;
            o_len_valid <= 1'b0;
        end
        else
        begin
            o_len_valid <= i_sample_valid;
            if (i_sample_valid)
                o_len <= use_cap ? len_cap : i_sample;
        end
    end

endmodule

/* src/wave_buffer.sv */
module wave_buffer (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic            i_sim_reset,
    input  logic            i_pipe_write,
    input  limb_pkg::half_t i_pipe_data,
    input  logic            i_pop,
    output limb_pkg::word_t o_sample,
    output logic            o_sample_valid
);
    import limb_pkg::*;

    // sample storage
    word_t mem [WAVE_DEPTH];

    // half-word assembly
    half_sel_e half_sel;
    half_t     lo_hold;

    // pointers and fill level
    logic [WAVE_AW-1:0] wr_ptr;
    logic [WAVE_AW-1:0] rd_ptr;
    logic [WAVE_AW:0]   stored_cnt;
    logic [WAVE_AW:0]   rd_next;

    logic clear;
    logic store;

    // either reset restarts the buffer
    assign clear = i_reset | i_sim_reset;

    // a sample completes on its high half
    assign store = i_pipe_write & (half_sel == HALF_HI);

    // read pointer plus one, one bit wider for the count compare
    assign rd_next = {1'b0, rd_ptr} + 1'b1;

    ////////////////////
    // pipe side
    ////////////////////

    // toggle on every accepted half-word, low first
    always_ff @(posedge i_clk)
    begin
        if (clear)
            half_sel <= HALF_LO;
        else if (i_pipe_write)
        begin
            if (half_sel == HALF_LO)
                half_sel <= HALF_HI;
            else
                half_sel <= HALF_LO;
        end
    end

    // hold low half until its partner arrives
    always_ff @(posedge i_clk)
    begin
        if (i_pipe_write && (half_sel == HALF_LO))
            lo_hold <= i_pipe_data;
    end

    always_ff @(posedge i_clk)
    begin
        if (store)
            mem[wr_ptr] <= {i_pipe_data, lo_hold};
    end

    // write pointer wraps, fill level sticks at full depth
    always_ff @(posedge i_clk)
    begin
        if (clear)
        begin
            wr_ptr     <= '0;
            stored_cnt <= '0;
        end
        else if (store)
        begin
            if (wr_ptr == WAVE_AW'(WAVE_DEPTH - 1))
                wr_ptr <= '0;
            else
                wr_ptr <= wr_ptr + 1'b1;
            if (stored_cnt != (WAVE_AW + 1)'(WAVE_DEPTH))
                stored_cnt <= stored_cnt + 1'b1;
        end
    end

    ////////////////////
    // playback side
    ////////////////////

    // read pointer cycles over the stored samples only
    always_ff @(posedge i_clk)
    begin
        if (clear)
        begin
            rd_ptr         <= '0;
            o_sample_valid <= 1'b0;
        end
        else
        begin
            o_sample_valid <= i_pop;
            if (i_pop && (stored_cnt != '0))
            begin
                if (rd_next >= stored_cnt)
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // empty buffer plays zero
    always_ff @(posedge i_clk)
    begin
        if (i_pop)
            o_sample <= (stored_cnt == '0) ? '0 : mem[rd_ptr];
    end

endmodule

/* src/param_bank.sv */
module param_bank (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic [15:0]                     i_trig,
    input  limb_pkg::half_t                 i_wire_lo,
    input  limb_pkg::half_t                 i_wire_hi,
    output logic [limb_pkg::HALF_CNT_W-1:0] o_half_cnt,
    output logic                            o_use_pxi,
    output limb_pkg::word_t                 o_len_pxi
);
    import limb_pkg::*;

    // decoded trigger slots
    logic load_half_cnt;
    logic load_len_select;
    logic load_len_pxi;
    // host wires as one word
    word_t wire_word;

    // each slot is a one-cycle pulse from the host
    assign load_half_cnt   = i_trig[TRIG_HALF_CNT];
    assign load_len_select = i_trig[TRIG_LEN_SELECT];
    assign load_len_pxi    = i_trig[TRIG_LEN_PXI];

    // high wire on top, as the host sends it
    assign wire_word = {i_wire_hi, i_wire_lo};

    ////////////////////
    // tick divider
    ////////////////////

    // half period of the simulation tick, low wire only
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_half_cnt <= DEF_HALF_CNT;
        else if (load_half_cnt)
            o_half_cnt <= HALF_CNT_W'(i_wire_lo);
    end

    ////////////////////
    // length source
    ////////////////////

    // any nonzero wire selects the fixed length
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_use_pxi <= DEF_USE_PXI;
        else if (load_len_select)
            o_use_pxi <= |wire_word;
    end

    // fixed muscle length from the host
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_len_pxi <= DEF_LEN_PXI;
        else if (load_len_pxi)
            o_len_pxi <= wire_word;
    end

    // remaining trigger slots belong to dropped parameters
    // and are left undecoded

endmodule

/* src/limb_pkg.sv */
package limb_pkg;

    ////////////////////
    // data widths
    ////////////////////

    // one float-pattern sample or muscle length
    typedef logic [31:0] word_t;
    // one host wire or pipe half-word
    typedef logic [15:0] half_t;

    // tick half count, as loaded from the low wire
    localparam int HALF_CNT_W = 18;

    // waveform memory
    localparam int WAVE_DEPTH = 1024;
    localparam int WAVE_AW    = 10;

    // spike count per window
    localparam int COUNT_W = 16;

    ////////////////////
    // reset defaults
    ////////////////////

    // 10 cycles per tick
    localparam logic [HALF_CNT_W-1:0] DEF_HALF_CNT = 18'd4;
    // 0.9 as IEEE single
    localparam word_t DEF_LEN_PXI = 32'h3F66_6666;
    // fixed length selected out of reset
    localparam logic DEF_USE_PXI = 1'b1;

    ////////////////////
    // encodings
    ////////////////////

    // bit index within the trigger word, one slot per parameter
    typedef enum logic [3:0] {
        TRIG_HALF_CNT   = 4'd0,
        TRIG_LEN_SELECT = 4'd7,
        TRIG_LEN_PXI    = 4'd8
    } trig_slot_e;

    // which half of a sample the next pipe write carries
    typedef enum logic {
        HALF_LO,
        HALF_HI
    } half_sel_e;

endpackage
